/* Makefile */
SRCS = paint_pkg.sv vga_sync.sv canvas_ram.sv canvas_mapper.sv paint_ctrl.sv \
       paint_canvas_top.sv tb_paint_canvas.sv

.PHONY: run clean

run: obj_dir/Vtb_paint_canvas
	./obj_dir/Vtb_paint_canvas | tee sim.log
	@if grep -q "test failed" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "test passed" sim.log || { echo "simulation ended early"; exit 1; }

obj_dir/Vtb_paint_canvas: $(SRCS) paint_canvas.f
	verilator --binary --timing --assert --top-module tb_paint_canvas -f paint_canvas.f

clean:
	rm -rf obj_dir sim.log

/* canvas_mapper.sv */
//*************************************************
// Cell addressing and paint merge
//*************************************************

`timescale 1ns/1ns

module canvas_mapper (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            cmd_valid,
  input  logic                            cmd_write,
  input  logic [paint_pkg::COL_BITS-1:0]  cmd_x,
  input  logic [paint_pkg::ROW_BITS-1:0]  cmd_y,
  input  logic                            cmd_color,
  output logic                            cmd_done,
  output logic                            cmd_rdata,
  input  logic [9:0]                      hpos,
  input  logic [9:0]                      vpos,
  input  logic                            active,
  input  logic                            hsync_raw,
  input  logic                            vsync_raw,
  output logic [paint_pkg::ADDR_BITS-1:0] paint_addr,
  output logic                            paint_we,
  output logic [paint_pkg::WORD_BITS-1:0] paint_wdata,
  input  logic [paint_pkg::WORD_BITS-1:0] paint_rdata,
  output logic [paint_pkg::ADDR_BITS-1:0] disp_addr,
  input  logic [paint_pkg::WORD_BITS-1:0] disp_rdata,
  output logic                            pixel,
  output logic                            hsync,
  output logic                            vsync
);

  import paint_pkg::*;

  typedef enum logic [1:0] {M_IDLE, M_READ, M_DATA, M_WRITE} mstate_t;

  // Bank is row / 6, followed by the column
  function automatic logic [ADDR_BITS-1:0] word_addr(input logic [9:0] row,
                                                     input logic [9:0] col);
    logic [9:0] bank;
    bank = 10'(row / WORD_BITS);
    return {bank[BANK_BITS-1:0], col[COL_BITS-1:0]};
  endfunction

  function automatic logic [SEL_BITS-1:0] bit_sel(input logic [9:0] row);
    logic [9:0] sel;
    sel = 10'(row % WORD_BITS);
    return sel[SEL_BITS-1:0];
  endfunction

  mstate_t              state;
  logic                 write_q;
  logic                 color_q;
  logic [ADDR_BITS-1:0] addr_q;
  logic [SEL_BITS-1:0]  sel_q;
  logic [WORD_BITS-1:0] merged;
  logic [WORD_BITS-1:0] merge_q;
  logic [9:0]           disp_col;
  logic [9:0]           disp_row;
  logic [SEL_BITS-1:0]  disp_sel_q;
  logic                 active_q;

  // Display lookup, one cycle through the RAM
  assign disp_col  = 10'(hpos / CELL_SIZE);
  assign disp_row  = 10'(vpos / CELL_SIZE);
  assign disp_addr = word_addr(disp_row, disp_col);

  always_ff @(posedge clk) begin
    if (reset) begin
      active_q <= 1'b0;
      hsync    <= 1'b1;
      vsync    <= 1'b1;
    end else begin
      active_q <= active;
      hsync    <= hsync_raw;
      vsync    <= vsync_raw;
    end
  end

  always_ff @(posedge clk) begin
    disp_sel_q <= bit_sel(disp_row);
  end

  assign pixel = active_q ? disp_rdata[disp_sel_q] : 1'b0;

  // Command sequencing: read word, then merge and write back for a paint
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= M_IDLE;
      write_q <= 1'b0;
    end else begin
      case (state)
        M_IDLE: begin
          if (cmd_valid) begin
            state   <= M_READ;
            write_q <= cmd_write;
          end
        end
        M_READ:  state <= M_DATA;
        M_DATA:  state <= write_q ? M_WRITE : M_IDLE;
        default: state <= M_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid && state == M_IDLE) begin
      addr_q  <= word_addr(10'(cmd_y), 10'(cmd_x));
      sel_q   <= bit_sel(10'(cmd_y));
      color_q <= cmd_color;
    end
    if (state == M_DATA) begin
      merge_q <= merged;
    end
  end

  // Only the selected cell changes
  always_comb begin
    merged        = paint_rdata;
    merged[sel_q] = color_q;
  end

  assign paint_addr  = addr_q;
  assign paint_we    = (state == M_WRITE);
  assign paint_wdata = merge_q;
  assign cmd_rdata   = paint_rdata[sel_q];
  assign cmd_done    = (state == M_DATA && !write_q) || (state == M_WRITE);

  a_cmd_range: assert property (@(posedge clk) disable iff (reset)
    cmd_valid |-> (cmd_x < 7'(CANVAS_W)) && (cmd_y < 6'(CANVAS_H)));

  a_cmd_idle: assert property (@(posedge clk) disable iff (reset)
    cmd_valid |-> state == M_IDLE);

endmodule

/* canvas_ram.sv */
//*************************************************
// Canvas word memory
//*************************************************

`timescale 1ns/1ns

module canvas_ram (
  input  logic                            clk,
  input  logic [paint_pkg::ADDR_BITS-1:0] disp_addr,
  output logic [paint_pkg::WORD_BITS-1:0] disp_rdata,
  input  logic [paint_pkg::ADDR_BITS-1:0] paint_addr,
  input  logic                            paint_we,
  input  logic [paint_pkg::WORD_BITS-1:0] paint_wdata,
  output logic [paint_pkg::WORD_BITS-1:0] paint_rdata
);

  import paint_pkg::*;

  localparam int DEPTH = 1 << ADDR_BITS;

  logic [WORD_BITS-1:0] mem [0:DEPTH-1];

  // Whole canvas starts white
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = RAM_INIT;
    end
  end

  // Display port, read only
  always_ff @(posedge clk) begin
    disp_rdata <= mem[disp_addr];
  end

  // Paint port returns the old word on a same-address write
  always_ff @(posedge clk) begin
    if (paint_we) begin
      mem[paint_addr] <= paint_wdata;
    end
    paint_rdata <= mem[paint_addr];
  end

endmodule

/* paint_canvas.f */
paint_pkg.sv
vga_sync.sv
canvas_ram.sv
canvas_mapper.sv
paint_ctrl.sv
paint_canvas_top.sv
tb_paint_canvas.sv

/* paint_canvas_top.sv */
//*************************************************
// Paint canvas top level
//*************************************************

`timescale 1ns/1ns

module paint_canvas_top (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [31:0] araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready,
  output logic        hsync,
  output logic        vsync,
  output logic        pixel,
  output logic [9:0]  hpos,
  output logic [9:0]  vpos
);

  import paint_pkg::*;

  logic                 cmd_valid;
  logic                 cmd_write;
  logic [COL_BITS-1:0]  cmd_x;
  logic [ROW_BITS-1:0]  cmd_y;
  logic                 cmd_color;
  logic                 cmd_done;
  logic                 cmd_rdata;
  logic                 active;
  logic                 hsync_raw;
  logic                 vsync_raw;
  logic [ADDR_BITS-1:0] paint_addr;
  logic                 paint_we;
  logic [WORD_BITS-1:0] paint_wdata;
  logic [WORD_BITS-1:0] paint_rdata;
  logic [ADDR_BITS-1:0] disp_addr;
  logic [WORD_BITS-1:0] disp_rdata;

  paint_ctrl u_ctrl (
    .clk, .reset,
    .awaddr, .awvalid, .awready,
    .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready,
    .cmd_valid, .cmd_write, .cmd_x, .cmd_y, .cmd_color,
    .cmd_done, .cmd_rdata
  );

  canvas_mapper u_mapper (
    .clk, .reset,
    .cmd_valid, .cmd_write, .cmd_x, .cmd_y, .cmd_color,
    .cmd_done, .cmd_rdata,
    .hpos, .vpos, .active, .hsync_raw, .vsync_raw,
    .paint_addr, .paint_we, .paint_wdata, .paint_rdata,
    .disp_addr, .disp_rdata,
    .pixel, .hsync, .vsync
  );

  canvas_ram u_ram (
    .clk,
    .disp_addr, .disp_rdata,
    .paint_addr, .paint_we, .paint_wdata, .paint_rdata
  );

  vga_sync u_sync (
    .clk, .reset,
    .hpos, .vpos, .active, .hsync_raw, .vsync_raw
  );

endmodule

/* paint_ctrl.sv */
//*************************************************
// AXI4-Lite register slave
//*************************************************

`timescale 1ns/1ns

module paint_ctrl (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [31:0]                    awaddr,
  input  logic                           awvalid,
  output logic                           awready,
  input  logic [31:0]                    wdata,
  input  logic [3:0]                     wstrb,
  input  logic                           wvalid,
  output logic                           wready,
  output logic [1:0]                     bresp,
  output logic                           bvalid,
  input  logic                           bready,
  input  logic [31:0]                    araddr,
  input  logic                           arvalid,
  output logic                           arready,
  output logic [31:0]                    rdata,
  output logic [1:0]                     rresp,
  output logic                           rvalid,
  input  logic                           rready,
  output logic                           cmd_valid,
  output logic                           cmd_write,
  output logic [paint_pkg::COL_BITS-1:0] cmd_x,
  output logic [paint_pkg::ROW_BITS-1:0] cmd_y,
  output logic                           cmd_color,
  input  logic                           cmd_done,
  input  logic                           cmd_rdata
);

  import paint_pkg::*;

  typedef enum logic [2:0] {S_IDLE, S_WCMD, S_RCMD, S_BRESP, S_RRESP} state_t;

  function automatic logic is_reg(input logic [31:0] addr, input logic [3:0] offset);
    return (addr[31:4] == 28'd0) && (addr[3:0] == offset);
  endfunction

  state_t              state;
  logic [COL_BITS-1:0] cursor_x;
  logic [ROW_BITS-1:0] cursor_y;
  logic                in_range;
  logic                aw_held;
  logic                w_held;
  logic [31:0]         awaddr_q;
  logic [31:0]         wdata_q;
  logic [3:0]          wstrb_q;
  logic                aw_fire;
  logic                w_fire;
  logic                ar_fire;
  logic                wr_go;
  logic [31:0]         wr_addr;
  logic [31:0]         wr_data;
  logic [3:0]          wr_strb;
  logic                paint_go;
  logic                cell_go;
  logic                busy;

  // Reads win over a write that has not started yet
  assign arready = (state == S_IDLE);
  assign awready = (state == S_IDLE) && !aw_held && !arvalid;
  assign wready  = (state == S_IDLE) && !w_held && !arvalid;

  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;
  assign ar_fire = arvalid && arready;

  // AW and W may arrive in either order
  assign wr_go   = (aw_held || aw_fire) && (w_held || w_fire);
  assign wr_addr = aw_held ? awaddr_q : awaddr;
  assign wr_data = w_held ? wdata_q : wdata;
  assign wr_strb = w_held ? wstrb_q : wstrb;

  assign in_range = (cursor_x < 7'(CANVAS_W)) && (cursor_y < 6'(CANVAS_H));
  assign paint_go = wr_go && is_reg(wr_addr, REG_PEN) && in_range && wr_strb[0];
  assign cell_go  = ar_fire && is_reg(araddr, REG_CELL) && in_range;
  assign busy     = (state != S_IDLE) || aw_held || w_held;

  assign cmd_valid = paint_go || cell_go;
  assign cmd_write = paint_go;
  assign cmd_color = wr_data[0];
  assign cmd_x     = cursor_x;
  assign cmd_y     = cursor_y;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= S_IDLE;
      aw_held  <= 1'b0;
      w_held   <= 1'b0;
      bvalid   <= 1'b0;
      rvalid   <= 1'b0;
      cursor_x <= '0;
      cursor_y <= '0;
    end else begin
      aw_held <= (aw_held || aw_fire) && !wr_go;
      w_held  <= (w_held || w_fire) && !wr_go;
      if (wr_go && is_reg(wr_addr, REG_CURSOR)) begin
        if (wr_strb[0]) cursor_x <= wr_data[COL_BITS-1:0];
        if (wr_strb[2]) cursor_y <= wr_data[16 +: ROW_BITS];
      end
      case (state)
        S_IDLE: begin
          if (paint_go) begin
            state <= S_WCMD;
          end else if (wr_go) begin
            bvalid <= 1'b1;
            state  <= S_BRESP;
          end else if (cell_go) begin
            state <= S_RCMD;
          end else if (ar_fire) begin
            rvalid <= 1'b1;
            state  <= S_RRESP;
          end
        end
        S_WCMD: begin
          if (cmd_done) begin
            bvalid <= 1'b1;
            state  <= S_BRESP;
          end
        end
        S_RCMD: begin
          if (cmd_done) begin
            rvalid <= 1'b1;
            state  <= S_RRESP;
          end
        end
        S_BRESP: begin
          if (bready) begin
            bvalid <= 1'b0;
            state  <= S_IDLE;
          end
        end
        default: begin
          if (rready) begin
            rvalid <= 1'b0;
            state  <= S_IDLE;
          end
        end
      endcase
    end
  end

  // Captured channel payloads and response values
  always_ff @(posedge clk) begin
    if (aw_fire) awaddr_q <= awaddr;
    if (w_fire) begin
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
    if (state == S_WCMD && cmd_done) begin
      bresp <= RESP_OKAY;
    end else if (wr_go && !paint_go) begin
      // Cursor writes and masked pen writes are accepted
      if (is_reg(wr_addr, REG_CURSOR) || (is_reg(wr_addr, REG_PEN) && in_range)) begin
        bresp <= RESP_OKAY;
      end else begin
        bresp <= RESP_SLVERR;
      end
    end
    if (state == S_RCMD && cmd_done) begin
      rdata <= {31'd0, cmd_rdata};
      rresp <= RESP_OKAY;
    end else if (ar_fire && !cell_go) begin
      rdata <= '0;
      rresp <= RESP_OKAY;
      if (is_reg(araddr, REG_CURSOR)) begin
        rdata <= {10'd0, cursor_y, 9'd0, cursor_x};
      end else if (is_reg(araddr, REG_STATUS)) begin
        rdata <= {31'd0, busy};
      end else begin
        rresp <= RESP_SLVERR;
      end
    end
  end

  a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
    bvalid && !bready |=> bvalid && $stable(bresp));

  a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
    rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata));

endmodule

/* paint_pkg.sv */
//*************************************************
// Paint canvas shared definitions
//*************************************************

package paint_pkg;

  // Canvas geometry, counted in cells
  localparam int CELL_SIZE = 8;
  localparam int CANVAS_W  = 80;
  localparam int CANVAS_H  = 60;

  // Six vertically adjacent cells share one RAM word
  localparam int WORD_BITS = 6;
  localparam int BANKS     = 10;
  localparam int COL_BITS  = 7;
  localparam int ROW_BITS  = 6;
  localparam int BANK_BITS = 4;
  localparam int SEL_BITS  = 3;
  localparam int ADDR_BITS = 11;

  // Blank canvas is white
  localparam logic [WORD_BITS-1:0] RAM_INIT = '1;

  // 640x480 at 60 Hz, horizontal in pixels
  localparam int H_ACTIVE     = 640;
  localparam int H_SYNC_START = 656;
  localparam int H_SYNC_END   = 752;
  localparam int H_TOTAL      = 800;

  // Vertical in lines
  localparam int V_ACTIVE     = 480;
  localparam int V_SYNC_START = 490;
  localparam int V_SYNC_END   = 492;
  localparam int V_TOTAL      = 525;

  // Register offsets
  localparam logic [3:0] REG_CURSOR = 4'h0;
  localparam logic [3:0] REG_PEN    = 4'h4;
  localparam logic [3:0] REG_CELL   = 4'h8;
  localparam logic [3:0] REG_STATUS = 4'hC;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* tb_paint_canvas.sv */
//**************************************************
// Paint canvas testbench
//**************************************************

`timescale 1ns/1ns

module tb_paint_canvas;

  localparam logic [31:0] ADDR_CURSOR  = 32'h0;
  localparam logic [31:0] ADDR_PEN     = 32'h4;
  localparam logic [31:0] ADDR_CELL    = 32'h8;
  localparam logic [1:0]  OKAY         = 2'b00;
  localparam logic [1:0]  SLVERR       = 2'b10;
  localparam int          FRAME_CYCLES = 800 * 525;
  // One frame of 420,000 cycles plus AXI traffic, with wide margin
  localparam int          MAX_CYCLES   = 1000000;
  localparam int          NUM_CELLS    = 8;

  logic        clk;
  logic        reset;
  logic [31:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [31:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  logic        hsync;
  logic        vsync;
  logic        pixel;
  logic [9:0]  hpos;
  logic [9:0]  vpos;

  // Reference canvas indexed [x][y], white at start
  logic        model [0:79][0:59];

  // Expected response of the transfer in flight
  logic [31:0] exp_rdata;
  logic [1:0]  exp_rresp;
  logic [1:0]  exp_bresp;
  int          exp_rlat;
  int          exp_blat;

  int          ar_age = 0;
  int          w_age = 0;
  int          rst_count = 0;
  int          cycles = 0;
  int          errors = 0;
  int          test_errors = 0;
  int          n_pass = 0;
  int          n_fail = 0;
  logic [9:0]  prev_h = '0;
  logic [9:0]  prev_v = '0;
  logic [9:0]  next_h;
  logic [9:0]  next_v;
  logic        exp_pixel;
  logic        disp_check = 1'b0;

  paint_canvas_top u_dut (
    .clk, .reset,
    .awaddr, .awvalid, .awready,
    .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready,
    .hsync, .vsync, .pixel, .hpos, .vpos
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Cycles since each handshake, plus last scan position
  always @(posedge clk) begin
    prev_h <= hpos;
    prev_v <= vpos;
    if (reset) rst_count <= rst_count + 1;
    if (arvalid && arready) ar_age <= 1;
    else if (ar_age != 0) ar_age <= ar_age + 1;
    if (awvalid && awready && wvalid && wready) w_age <= 1;
    else if (w_age != 0) w_age <= w_age + 1;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("test failed");
      $finish;
    end
  end

  // Cell under the previous scan position
  always_comb begin
    exp_pixel = 1'b0;
    if (prev_h < 10'd640 && prev_v < 10'd480) begin
      exp_pixel = model[int'(prev_h) / 8][int'(prev_v) / 8];
    end
  end

  // Scan position one pixel after the previous one, 800 by 525
  always_comb begin
    next_h = prev_h + 10'd1;
    next_v = prev_v;
    if (prev_h == 10'd799) begin
      next_h = '0;
      next_v = (prev_v == 10'd524) ? 10'd0 : prev_v + 10'd1;
    end
  end

  a_reset_state: assert property (@(posedge clk)
    ((reset && rst_count >= 1) || $fell(reset)) |->
      !bvalid && !rvalid && hsync && vsync && !pixel && hpos == '0 && vpos == '0)
    else begin
      errors = errors + 1;
      $display("mismatch reset state: bvalid %h rvalid %h hsync %h vsync %h pixel %h",
               $sampled(bvalid), $sampled(rvalid), $sampled(hsync), $sampled(vsync),
               $sampled(pixel));
      $display("mismatch reset state: hpos %h vpos %h", $sampled(hpos), $sampled(vpos));
    end

  a_ready_after_reset: assert property (@(posedge clk)
    $fell(reset) |-> awready && wready && arready)
    else begin
      errors = errors + 1;
      $display("mismatch ready after reset: awready %h wready %h arready %h",
               $sampled(awready), $sampled(wready), $sampled(arready));
    end

  a_scan: assert property (@(posedge clk) disable iff (reset)
    !$fell(reset) |-> hpos == next_h && vpos == next_v)
    else begin
      errors = errors + 1;
      $display("mismatch scan position: got h %h v %h expected h %h v %h",
               $sampled(hpos), $sampled(vpos), $sampled(next_h), $sampled(next_v));
    end

  a_rlat: assert property (@(posedge clk) disable iff (reset)
    $rose(rvalid) |-> ar_age == exp_rlat)
    else begin
      errors = errors + 1;
      $display("mismatch rvalid latency: got %h expected %h", $sampled(ar_age), exp_rlat);
    end

  a_blat: assert property (@(posedge clk) disable iff (reset)
    $rose(bvalid) |-> w_age == exp_blat)
    else begin
      errors = errors + 1;
      $display("mismatch bvalid latency: got %h expected %h", $sampled(w_age), exp_blat);
    end

  a_rresp: assert property (@(posedge clk) disable iff (reset)
    rvalid && rready |-> rresp == exp_rresp)
    else begin
      errors = errors + 1;
      $display("mismatch rresp: got %h expected %h", $sampled(rresp), exp_rresp);
    end

  a_rdata: assert property (@(posedge clk) disable iff (reset)
    rvalid && rready && exp_rresp == OKAY |-> rdata == exp_rdata)
    else begin
      errors = errors + 1;
      $display("mismatch rdata: got %h expected %h", $sampled(rdata), exp_rdata);
    end

  a_bresp: assert property (@(posedge clk) disable iff (reset)
    bvalid && bready |-> bresp == exp_bresp)
    else begin
      errors = errors + 1;
      $display("mismatch bresp: got %h expected %h", $sampled(bresp), exp_bresp);
    end

  a_bhold: assert property (@(posedge clk) disable iff (reset)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
      errors = errors + 1;
      $display("write response dropped or changed while bready was low");
    end

  a_pixel: assert property (@(posedge clk) disable iff (reset || !disp_check)
    pixel == exp_pixel)
    else begin
      errors = errors + 1;
      $display("mismatch pixel at h %h v %h: got %h expected %h",
               $sampled(prev_h), $sampled(prev_v), $sampled(pixel), $sampled(exp_pixel));
    end

  a_hsync: assert property (@(posedge clk) disable iff (reset)
    hsync == !(prev_h >= 10'd656 && prev_h <= 10'd751))
    else begin
      errors = errors + 1;
      $display("mismatch hsync at h %h: got %h", $sampled(prev_h), $sampled(hsync));
    end

  a_vsync: assert property (@(posedge clk) disable iff (reset)
    vsync == !(prev_v == 10'd490 || prev_v == 10'd491))
    else begin
      errors = errors + 1;
      $display("mismatch vsync at v %h: got %h", $sampled(prev_v), $sampled(vsync));
    end

  // Stall holds bready low for that many cycles once bvalid is up
  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                           input logic [1:0] resp, input int lat, input int stall);
    @(posedge clk);
    exp_bresp = resp;
    exp_blat  = lat;
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= 4'hf;
    wvalid  <= 1'b1;
    if (stall > 0) bready <= 1'b0;
    @(negedge clk);
    while (!(awready && wready)) @(negedge clk);
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    repeat (stall) @(posedge clk);
    if (stall > 0) bready <= 1'b1;
    @(posedge clk);
  endtask

  task automatic read_reg(input logic [31:0] addr, input logic [31:0] data,
                          input logic [1:0] resp, input int lat);
    @(posedge clk);
    exp_rdata = data;
    exp_rresp = resp;
    exp_rlat  = lat;
    araddr  <= addr;
    arvalid <= 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    arvalid <= 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    @(posedge clk);
  endtask

  task automatic set_cursor(input int x, input int y);
    write_reg(ADDR_CURSOR, (32'(y) << 16) | 32'(x), OKAY, 1, 0);
  endtask

  task automatic paint_cell(input int x, input int y, input logic color, input int stall);
    set_cursor(x, y);
    write_reg(ADDR_PEN, {31'd0, color}, OKAY, 4, stall);
    model[x][y] = color;
  endtask

  task automatic check_cell(input int x, input int y);
    set_cursor(x, y);
    read_reg(ADDR_CELL, {31'd0, model[x][y]}, OKAY, 3);
  endtask

  // All six cells sharing the RAM word of row y
  task automatic check_word(input int x, input int y);
    int base;
    base = (y / 6) * 6;
    for (int r = base; r < base + 6; r++) begin
      check_cell(x, r);
    end
  endtask

  task automatic finish_test(input string name);
    if (errors == test_errors) begin
      n_pass = n_pass + 1;
      $display("%-14s ok", name);
    end else begin
      n_fail = n_fail + 1;
      $display("%-14s %0d errors", name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  initial begin
    int x;
    int y;
    void'($urandom(32'hfbac6140));
    for (int i = 0; i < 80; i++) begin
      for (int j = 0; j < 60; j++) begin
        model[i][j] = 1'b1;
      end
    end
    reset   = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b1;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    repeat (3) @(posedge clk);
    finish_test("reset_state");

    for (int n = 0; n < NUM_CELLS; n++) begin
      check_cell(int'($urandom % 80), int'($urandom % 60));
    end
    finish_test("blank_readback");

    for (int n = 0; n < NUM_CELLS; n++) begin
      x = int'($urandom % 80);
      y = int'($urandom % 60);
      paint_cell(x, y, 1'($urandom), 0);
      check_word(x, y);
    end
    finish_test("paint_merge");

    // Out of range cursor in either direction
    y = int'($urandom % 60);
    x = int'($urandom % 80);
    set_cursor(80, y);
    write_reg(ADDR_PEN, 32'd0, SLVERR, 1, 0);
    read_reg(ADDR_CELL, 32'd0, SLVERR, 1);
    set_cursor(x, 60);
    write_reg(ADDR_PEN, 32'd0, SLVERR, 1, 0);
    read_reg(ADDR_CELL, 32'd0, SLVERR, 1);
    check_word(79, y);
    check_word(x, 59);
    finish_test("range_errors");

    x = int'($urandom % 80);
    y = int'($urandom % 60);
    paint_cell(x, y, ~model[x][y], 6);
    check_word(x, y);
    finish_test("back_pressure");

    disp_check <= 1'b1;
    repeat (FRAME_CYCLES + 10) @(posedge clk);
    disp_check <= 1'b0;
    finish_test("display_sync");

    $display("tests: %0d passed, %0d failed, %0d check errors", n_pass, n_fail, errors);
    if (n_fail == 0 && errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* vga_sync.sv */
//*************************************************
// VGA scan timing
//*************************************************

`timescale 1ns/1ns

module vga_sync (
  input  logic       clk,
  input  logic       reset,
  output logic [9:0] hpos,
  output logic [9:0] vpos,
  output logic       active,
  output logic       hsync_raw,
  output logic       vsync_raw
);

  import paint_pkg::*;

  logic line_end;
  logic frame_end;

  assign line_end  = (hpos == 10'(H_TOTAL - 1));
  assign frame_end = (vpos == 10'(V_TOTAL - 1));

  // Pixel and line counters, one pixel per clock
  always_ff @(posedge clk) begin
    if (reset) begin
      hpos <= '0;
      vpos <= '0;
    end else if (line_end) begin
      hpos <= '0;
      if (frame_end) begin
        vpos <= '0;
      end else begin
        vpos <= vpos + 10'd1;
      end
    end else begin
      hpos <= hpos + 10'd1;
    end
  end

  assign active = (hpos < 10'(H_ACTIVE)) && (vpos < 10'(V_ACTIVE));

  // Both syncs are active low
  assign hsync_raw = !((hpos >= 10'(H_SYNC_START)) && (hpos < 10'(H_SYNC_END)));
  assign vsync_raw = !((vpos >= 10'(V_SYNC_START)) && (vpos < 10'(V_SYNC_END)));

  a_hpos_range: assert property (@(posedge clk) disable iff (reset)
    hpos < 10'(H_TOTAL) && vpos < 10'(V_TOTAL));

endmodule
